// File: hw/acq_consts.svh
// shared sizes of the capture core, pulled in with `include wherever a width or depth is needed
`ifndef ACQ_CONSTS_SVH
`define ACQ_CONSTS_SVH

////////////////////
// adc side
////////////////////

`define ADC_W       14  // raw and converted sample width
`define ADC_CH      4   // channels on the adc bus

////////////////////
// capture side
////////////////////

`define ACQ_UNITS   2   // capture units, one per channel pair
`define ACQ_DEPTH   16  // words stored per unit
`define ACQ_DECIM   2   // keep one pair out of this many

// credits per writer, equal to the arbiter queue depth
`define WR_CREDITS  2

// memory address width, covers ACQ_UNITS * ACQ_DEPTH words
`define MEM_AW      5

`endif

// File: hw/sample_pkg.sv
// sample and capture state types, imported by the front end, the capture units and the top
`include "acq_consts.svh"

package sample_pkg;

  ////////////////////
  // samples
  ////////////////////

  // two's complement sample after conversion
  typedef logic signed [`ADC_W-1:0] sample_t;

  // one channel pair, a sits in the upper half
  typedef struct packed {
    sample_t a;  // trigger source
    sample_t b;
  } sample_pair_t;

  ////////////////////
  // capture fsm
  ////////////////////

  typedef enum logic [2:0] {
    CAP_IDLE  = 3'd0,  // out of reset, nothing stored
    CAP_ARMED = 3'd1,  // watching channel a for a crossing
    CAP_RUN   = 3'd2,  // sending decimated pairs
    CAP_DRAIN = 3'd3,  // waiting for the last credits
    CAP_DONE  = 3'd4   // region complete
  } cap_state_e;

endpackage

// File: hw/mem_wr_pkg.sv
// types of the sample memory write path, imported by the write interface, arbiter, memory and top
`include "acq_consts.svh"

package mem_wr_pkg;

  import sample_pkg::*;

  ////////////////////
  // memory words
  ////////////////////

  // word address into the shared memory
  typedef logic [`MEM_AW-1:0] mem_addr_t;

  // one stored word is a full channel pair, 2 x ADC_W bits
  typedef sample_pair_t mem_word_t;

  ////////////////////
  // writers
  ////////////////////

  // selects one capture unit, also its memory region
  typedef logic [$clog2(`ACQ_UNITS)-1:0] unit_id_t;

endpackage

// File: hw/mem_wr_if.sv
// credit-based write channel from one capture unit into the sample arbiter
`include "acq_consts.svh"

interface mem_wr_if import mem_wr_pkg::*; ();

  // writer to arbiter, one beat per cycle at most
  logic      wr_valid;  // beat present, costs one credit
  mem_addr_t wr_addr;   // absolute memory address
  mem_word_t wr_data;   // sample pair to store

  // arbiter to writer
  logic      credit;    // one-cycle pulse, one queue slot freed

  // capture unit side
  modport writer (
    output wr_valid,
    output wr_addr,
    output wr_data,
    input  credit
  );

  // arbiter side
  modport arbiter (
    input  wr_valid,
    input  wr_addr,
    input  wr_data,
    output credit
  );

endinterface

// File: hw/adc_frontend.sv
// converts the raw adc words to two's complement and registers them twice before capture
`include "acq_consts.svh"

module adc_frontend import sample_pkg::*; (
  input  logic                            adc_clk_01,
  input  logic                            reset_i,
  input  logic [`ADC_CH-1:0][`ADC_W-1:0]  adc_dat_i,  // raw, offset binary with neg slope
  output sample_t [`ADC_CH-1:0]           adc_smp_o   // converted, 2 cycles later
);

  ////////////////////
  // conversion
  ////////////////////

  sample_t [`ADC_CH-1:0] adc_conv;    // combinational result
  sample_t [`ADC_CH-1:0] adc_dat_r;   // first stage
  sample_t [`ADC_CH-1:0] adc_dat_rr;  // second stage, feeds the units

  // keep msb, flip the rest
  always_comb begin
    for (int ch = 0; ch < `ADC_CH; ch++) begin
      adc_conv[ch] = {adc_dat_i[ch][`ADC_W-1], ~adc_dat_i[ch][`ADC_W-2:0]};
    end
  end

  ////////////////////
  // pipeline
  ////////////////////

  always_ff @(posedge adc_clk_01) begin
    if (reset_i) begin
      adc_dat_r  <= '0;  // units see zero until real data arrives
      adc_dat_rr <= '0;
    end else begin
      adc_dat_r  <= adc_conv;
      adc_dat_rr <= adc_dat_r;
    end
  end

  assign adc_smp_o = adc_dat_rr;

endmodule

// File: hw/capture_unit.sv
// one channel pair: level trigger on channel a, decimation, and credit-limited writes to its region
`include "acq_consts.svh"

module capture_unit import sample_pkg::*, mem_wr_pkg::*; #(
  parameter unit_id_t UNIT_ID = '0  // picks the memory region
) (
  input  logic         adc_clk_01,
  input  logic         reset_i,
  input  sample_pair_t smp_i,         // converted pair, one per cycle
  input  logic         arm_i,         // start waiting for a trigger
  input  sample_t      trig_level_i,  // rising threshold on channel a
  output logic         done_o,        // whole region in memory
  mem_wr_if.writer     wr
);

  localparam int CW = $clog2(`WR_CREDITS + 1);                       // credit counter
  localparam int DW = (`ACQ_DECIM > 1) ? $clog2(`ACQ_DECIM) : 1;     // decimation counter
  localparam int IW = $clog2(`ACQ_DEPTH);                            // word index
  localparam mem_addr_t BASE = mem_addr_t'(UNIT_ID * `ACQ_DEPTH);    // region start

  cap_state_e   state_q, state_d;
  sample_t      prev_a_q;     // last channel a value, for edge detect
  logic         seeded_q;     // prev_a_q holds a sample taken since arming
  logic         hold_q;       // pair waiting for a credit
  sample_pair_t hold_pair_q;
  logic [DW-1:0] dec_cnt_q;   // pairs left to skip
  logic [IW-1:0] idx_q;       // words already sent
  logic [CW-1:0] cred_q;      // free slots in the arbiter queue
  logic         wr_valid_q;
  mem_addr_t    wr_addr_q;
  mem_word_t    wr_data_q;

  logic         arm_go, trig_hit, take, send, last;
  sample_pair_t out_pair;

  ////////////////////
  // trigger and decimation
  ////////////////////

  assign arm_go   = ((state_q == CAP_IDLE) || (state_q == CAP_DONE)) && arm_i;
  // first crossing from below, needs a seeded previous sample
  assign trig_hit = (state_q == CAP_ARMED) && seeded_q &&
                    (smp_i.a >= trig_level_i) && (prev_a_q < trig_level_i);
  assign take     = trig_hit || ((state_q == CAP_RUN) && !hold_q && (dec_cnt_q == '0));
  assign send     = (take || hold_q) && (cred_q != '0);  // a beat costs one credit
  assign out_pair = hold_q ? hold_pair_q : smp_i;        // held word goes first
  assign last     = send && (idx_q == IW'(`ACQ_DEPTH - 1));

  always_comb begin
    state_d = state_q;
    case (state_q)
      CAP_IDLE,
      CAP_DONE:  if (arm_i) state_d = CAP_ARMED;
      CAP_ARMED: if (trig_hit) state_d = CAP_RUN;
      CAP_RUN:   if (last) state_d = CAP_DRAIN;
      CAP_DRAIN: if (cred_q == CW'(`WR_CREDITS)) state_d = CAP_DONE;  // all words in memory
      default:   state_d = CAP_IDLE;
    endcase
  end

  ////////////////////
  // control state
  ////////////////////

  always_ff @(posedge adc_clk_01) begin
    if (reset_i) begin
      state_q    <= CAP_IDLE;
      seeded_q   <= 1'b0;
      hold_q     <= 1'b0;
      dec_cnt_q  <= '0;
      idx_q      <= '0;
      cred_q     <= CW'(`WR_CREDITS);  // queue empty
      wr_valid_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      wr_valid_q <= send;
      cred_q     <= cred_q - CW'(send) + CW'(wr.credit);
      if (arm_go) begin
        seeded_q <= 1'b0;  // next sample only seeds
        idx_q    <= '0;
      end else if (send) begin
        idx_q <= idx_q + 1'b1;
      end
      if (state_q == CAP_ARMED) seeded_q <= 1'b1;
      if (send) hold_q <= 1'b0;
      else if (take) hold_q <= 1'b1;  // out of credits, keep the pair
      if (trig_hit) begin
        dec_cnt_q <= DW'(`ACQ_DECIM - 1);  // skip after the trigger pair
      end else if ((state_q == CAP_RUN) && !hold_q) begin
        dec_cnt_q <= take ? DW'(`ACQ_DECIM - 1) : dec_cnt_q - 1'b1;
      end  // frozen while a word waits
    end
  end

  // payload, no reset
  always_ff @(posedge adc_clk_01) begin
    prev_a_q <= smp_i.a;
    if (take && !send) hold_pair_q <= smp_i;
    if (send) begin
      wr_addr_q <= BASE + mem_addr_t'(idx_q);
      wr_data_q <= out_pair;
    end
  end

  ////////////////////
  // outputs
  ////////////////////

  assign wr.wr_valid = wr_valid_q;
  assign wr.wr_addr  = wr_addr_q;
  assign wr.wr_data  = wr_data_q;
  assign done_o      = (state_q == CAP_DONE);

endmodule

// File: hw/sample_arbiter.sv
// queues each writer's beats and moves one entry per cycle into the sample memory, round robin
`include "acq_consts.svh"

module sample_arbiter import mem_wr_pkg::*; (
  input  logic       adc_clk_01,
  input  logic       reset_i,
  mem_wr_if.arbiter  wr0,         // unit 0
  mem_wr_if.arbiter  wr1,         // unit 1
  output logic       mem_we_o,
  output mem_addr_t  mem_addr_o,
  output mem_word_t  mem_data_o
);

  localparam int PW = (`WR_CREDITS > 1) ? $clog2(`WR_CREDITS) : 1;  // queue pointer
  localparam int CW = $clog2(`WR_CREDITS + 1);                      // fill count

  logic [`ACQ_UNITS-1:0] push, pop, q_empty;
  mem_addr_t     in_addr [`ACQ_UNITS];
  mem_word_t     in_data [`ACQ_UNITS];
  mem_addr_t     q_addr  [`ACQ_UNITS][`WR_CREDITS];  // queue storage
  mem_word_t     q_data  [`ACQ_UNITS][`WR_CREDITS];
  logic [PW-1:0] wr_ptr_q [`ACQ_UNITS];
  logic [PW-1:0] rd_ptr_q [`ACQ_UNITS];
  logic [CW-1:0] q_cnt_q  [`ACQ_UNITS];
  unit_id_t      rr_q;     // writer with priority this cycle
  unit_id_t      sel;      // writer popped this cycle
  logic          pop_any;

  function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
    return (p == PW'(`WR_CREDITS - 1)) ? '0 : p + 1'b1;
  endfunction

  ////////////////////
  // writer ports
  ////////////////////

  assign push[0]    = wr0.wr_valid;
  assign in_addr[0] = wr0.wr_addr;
  assign in_data[0] = wr0.wr_data;
  assign push[1]    = wr1.wr_valid;
  assign in_addr[1] = wr1.wr_addr;
  assign in_data[1] = wr1.wr_data;
  assign wr0.credit = pop[0];  // slot freed as the entry goes out
  assign wr1.credit = pop[1];

  ////////////////////
  // round robin
  ////////////////////

  always_comb begin
    int unsigned cand;
    sel     = rr_q;
    pop_any = 1'b0;
    for (int u = 0; u < `ACQ_UNITS; u++) q_empty[u] = (q_cnt_q[u] == '0);
    // walk from the far end so the writer nearest rr_q wins
    for (int k = `ACQ_UNITS - 1; k >= 0; k--) begin
      cand = (int'(rr_q) + k) % `ACQ_UNITS;
      if (!q_empty[cand]) begin
        sel     = unit_id_t'(cand);
        pop_any = 1'b1;
      end
    end
    pop      = '0;
    pop[sel] = pop_any;
  end

  always_ff @(posedge adc_clk_01) begin
    if (reset_i) begin
      rr_q <= '0;
      for (int u = 0; u < `ACQ_UNITS; u++) begin
        wr_ptr_q[u] <= '0;
        rd_ptr_q[u] <= '0;
        q_cnt_q[u]  <= '0;
      end
    end else begin
      if (pop_any) rr_q <= unit_id_t'((int'(sel) + 1) % `ACQ_UNITS);  // served one goes last
      for (int u = 0; u < `ACQ_UNITS; u++) begin
        if (push[u]) wr_ptr_q[u] <= ptr_inc(wr_ptr_q[u]);
        if (pop[u])  rd_ptr_q[u] <= ptr_inc(rd_ptr_q[u]);
        q_cnt_q[u] <= q_cnt_q[u] + CW'(push[u]) - CW'(pop[u]);
      end
    end
  end

  // queue storage
  always_ff @(posedge adc_clk_01) begin
    for (int u = 0; u < `ACQ_UNITS; u++) begin
      if (push[u]) begin
        q_addr[u][wr_ptr_q[u]] <= in_addr[u];
        q_data[u][wr_ptr_q[u]] <= in_data[u];
      end
    end
  end

  // head of the selected queue straight to the memory
  assign mem_we_o   = pop_any;
  assign mem_addr_o = q_addr[sel][rd_ptr_q[sel]];
  assign mem_data_o = q_data[sel][rd_ptr_q[sel]];

endmodule

// File: hw/sample_ram.sv
// shared sample memory, written by the arbiter and read back by the host one cycle after the address
`include "acq_consts.svh"

module sample_ram import mem_wr_pkg::*; (
  input  logic       adc_clk_01,
  input  logic       mem_we_i,    // from the arbiter
  input  mem_addr_t  mem_addr_i,
  input  mem_word_t  mem_data_i,
  input  mem_addr_t  rd_addr_i,   // host side
  output mem_word_t  rd_data_o    // registered
);

  ////////////////////
  // storage
  ////////////////////

  // one region of ACQ_DEPTH words per unit
  mem_word_t mem [`ACQ_UNITS * `ACQ_DEPTH];

  always_ff @(posedge adc_clk_01) begin
    if (mem_we_i) mem[mem_addr_i] <= mem_data_i;
  end

  ////////////////////
  // read port
  ////////////////////

  always_ff @(posedge adc_clk_01) begin
    rd_data_o <= mem[rd_addr_i];  // one cycle latency
  end

endmodule

// File: hw/acq_top.sv
// top of the capture core: front end, two capture units, sample arbiter and memory on adc_clk_01
`include "acq_consts.svh"

module acq_top import sample_pkg::*, mem_wr_pkg::*; (
  input  logic                            adc_clk_01,
  input  logic                            reset_i,       // synchronous, active high
  input  logic [`ADC_CH-1:0][`ADC_W-1:0]  adc_dat_i,     // raw adc words
  input  logic [`ACQ_UNITS-1:0]           arm_i,         // one per unit
  input  sample_t                         trig_level_i,  // shared threshold
  output logic [`ACQ_UNITS-1:0]           done_o,
  input  mem_addr_t                       rd_addr_i,     // host readback
  output mem_word_t                       rd_data_o
);

  sample_t [`ADC_CH-1:0] adc_smp;         // converted channels
  sample_pair_t          smp_01, smp_23;  // unit inputs
  logic                  mem_we;
  mem_addr_t             mem_addr;
  mem_word_t             mem_data;

  mem_wr_if wr_if_0 ();  // unit 0 to arbiter
  mem_wr_if wr_if_1 ();  // unit 1 to arbiter

  ////////////////////
  // adc front end
  ////////////////////

  adc_frontend i_frontend (
    .adc_clk_01 (adc_clk_01),
    .reset_i    (reset_i   ),
    .adc_dat_i  (adc_dat_i ),
    .adc_smp_o  (adc_smp   )
  );

  assign smp_01 = '{a: adc_smp[0], b: adc_smp[1]};
  assign smp_23 = '{a: adc_smp[2], b: adc_smp[3]};

  ////////////////////
  // capture units
  ////////////////////

  capture_unit #(.UNIT_ID (unit_id_t'(0))) i_cap_0 (
    .adc_clk_01   (adc_clk_01  ),
    .reset_i      (reset_i     ),
    .smp_i        (smp_01      ),  // ch 0 and 1
    .arm_i        (arm_i[0]    ),
    .trig_level_i (trig_level_i),
    .done_o       (done_o[0]   ),
    .wr           (wr_if_0     )
  );

  capture_unit #(.UNIT_ID (unit_id_t'(1))) i_cap_1 (
    .adc_clk_01   (adc_clk_01  ),
    .reset_i      (reset_i     ),
    .smp_i        (smp_23      ),  // ch 2 and 3
    .arm_i        (arm_i[1]    ),
    .trig_level_i (trig_level_i),
    .done_o       (done_o[1]   ),
    .wr           (wr_if_1     )
  );

  ////////////////////
  // shared memory
  ////////////////////

  sample_arbiter i_arbiter (
    .adc_clk_01 (adc_clk_01),
    .reset_i    (reset_i   ),
    .wr0        (wr_if_0   ),
    .wr1        (wr_if_1   ),
    .mem_we_o   (mem_we    ),
    .mem_addr_o (mem_addr  ),
    .mem_data_o (mem_data  )
  );

  sample_ram i_ram (
    .adc_clk_01 (adc_clk_01),
    .mem_we_i   (mem_we    ),
    .mem_addr_i (mem_addr  ),
    .mem_data_i (mem_data  ),
    .rd_addr_i  (rd_addr_i ),
    .rd_data_o  (rd_data_o )
  );

endmodule

// File: sim/acq_clkgen.sv
// clock and synchronous reset source for the capture core testbench, one instance in acq_tb
module acq_clkgen #(
  parameter int PERIOD  = 40,  // time units
  parameter int RST_CYC = 3    // reset length in clock cycles
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (RST_CYC) @(posedge clk_o);
    #1 rst_o = 1'b0;  // released just after the edge
  end

endmodule

// File: sim/acq_sva.sv
// arbiter assertions on queue fill, credit return and memory writes, attached to sample_arbiter by bind
`include "acq_consts.svh"

module acq_sva (
  input logic                              adc_clk_01,
  input logic                              reset_i,
  input logic [`ACQ_UNITS-1:0]             push_i,     // beat into each queue
  input logic [`ACQ_UNITS-1:0]             pop_i,      // entry out and credit back
  input logic [$clog2(`WR_CREDITS+1)-1:0]  cnt0_i,     // queue 0 fill
  input logic [$clog2(`WR_CREDITS+1)-1:0]  cnt1_i,     // queue 1 fill
  input logic                              mem_we_i,
  input logic [`MEM_AW-1:0]                mem_addr_i  // write address into the memory
);

  localparam int CW = $clog2(`WR_CREDITS + 1);
  localparam logic [CW-1:0] FULL = CW'(`WR_CREDITS);

  int held [`ACQ_UNITS];  // beats seen going in and not yet out

  // own count of queued beats from the port activity
  always_ff @(posedge adc_clk_01) begin
    if (reset_i) begin
      for (int u = 0; u < `ACQ_UNITS; u++) held[u] <= 0;
    end else begin
      for (int u = 0; u < `ACQ_UNITS; u++) begin
        held[u] <= held[u] + int'(push_i[u]) - int'(pop_i[u]);
      end
    end
  end

  ////////////////////
  // queue fill
  ////////////////////

  // a full queue only takes a beat while one leaves
  q0_overflow: assert property (@(posedge adc_clk_01) disable iff (reset_i)
    (cnt0_i <= FULL) && ((push_i[0] && (cnt0_i == FULL)) -> pop_i[0]))
    else $error("queue 0 written while full");

  q1_overflow: assert property (@(posedge adc_clk_01) disable iff (reset_i)
    (cnt1_i <= FULL) && ((push_i[1] && (cnt1_i == FULL)) -> pop_i[1]))
    else $error("queue 1 written while full");

  ////////////////////
  // credit return
  ////////////////////

  q0_credit: assert property (@(posedge adc_clk_01) disable iff (reset_i)
    pop_i[0] |-> (held[0] > 0))  // pulse needs a beat that went in earlier
    else $error("credit returned from empty queue 0");

  q1_credit: assert property (@(posedge adc_clk_01) disable iff (reset_i)
    pop_i[1] |-> (held[1] > 0))
    else $error("credit returned from empty queue 1");

  ////////////////////
  // memory port
  ////////////////////

  // each write belongs to exactly one writer and lands in its region
  one_write: assert property (@(posedge adc_clk_01) disable iff (reset_i)
    mem_we_i |-> ($onehot(pop_i) && (pop_i[1] == (int'(mem_addr_i) >= `ACQ_DEPTH))))
    else $error("memory write without a single owning writer");

endmodule

// File: sim/acq_tb.sv
// testbench for acq_top: table rows of arm, level and waveform, reference model and memory readback
`include "acq_consts.svh"

module acq_tb import sample_pkg::*, mem_wr_pkg::*; ();

  localparam int PERIOD   = 40;
  localparam int RST_CYC  = 3;
  localparam int DRV_DLY  = 2;   // input skew after the rising edge
  localparam int AW       = `ADC_W;
  localparam int N_ROWS   = 4;
  localparam int N_SMP    = 56;  // waveform cycles per row
  localparam int ARM_AT   = 2;   // waveform index that carries arm_i
  localparam int DONE_TMO = 64;  // cycles allowed after the waveform
  localparam int N_WORDS  = `ACQ_UNITS * `ACQ_DEPTH;
  localparam int ROW_CYC  = N_SMP + DONE_TMO + N_WORDS + 2;
  localparam int WDOG_T   = 2 * (RST_CYC + 2 + N_ROWS * ROW_CYC) * PERIOD;

  logic                           adc_clk_01;
  logic                           reset_i;
  logic [`ADC_CH-1:0][`ADC_W-1:0] adc_dat;
  logic [`ACQ_UNITS-1:0]          arm;
  sample_t                        trig_level;
  logic [`ACQ_UNITS-1:0]          done;
  mem_addr_t                      rd_addr;
  mem_word_t                      rd_data;

  ////////////////////
  // table and model state
  ////////////////////

  logic [`ACQ_UNITS-1:0]          arm_tab   [N_ROWS];
  sample_t                        lvl_tab   [N_ROWS];
  logic [`ACQ_UNITS-1:0]          done_tab  [N_ROWS];  // done_o expected after the row
  logic [`ADC_CH-1:0][`ADC_W-1:0] start_tab [N_ROWS];  // raw ramp start per channel
  logic [`ADC_CH-1:0][`ADC_W-1:0] step_tab  [N_ROWS];  // zero step selects lfsr data

  logic [`ADC_W-1:0]     wave [N_SMP][`ADC_CH];  // raw words of the current row
  mem_word_t             exp_mem [N_WORDS];
  logic [`ACQ_UNITS-1:0] exp_valid;              // region holds known data
  logic [15:0]           lfsr_q;
  int                    errors;

  acq_clkgen #(.PERIOD (PERIOD), .RST_CYC (RST_CYC)) i_clkgen (
    .clk_o (adc_clk_01),
    .rst_o (reset_i   )
  );

  acq_top i_acq_top (
    .adc_clk_01   (adc_clk_01),
    .reset_i      (reset_i   ),
    .adc_dat_i    (adc_dat   ),
    .arm_i        (arm       ),
    .trig_level_i (trig_level),
    .done_o       (done      ),
    .rd_addr_i    (rd_addr   ),
    .rd_data_o    (rd_data   )
  );

  bind sample_arbiter acq_sva i_sva (
    .adc_clk_01 (adc_clk_01 ),
    .reset_i    (reset_i    ),
    .push_i     (push       ),
    .pop_i      (pop        ),
    .cnt0_i     (q_cnt_q[0] ),
    .cnt1_i     (q_cnt_q[1] ),
    .mem_we_i   (mem_we_o   ),
    .mem_addr_i (mem_addr_o )
  );

  ////////////////////
  // helpers
  ////////////////////

  // offset binary to two's complement by an xor mask over the lower bits
  function automatic sample_t convert_raw(input logic [`ADC_W-1:0] raw);
    return sample_t'(raw ^ {1'b0, {(`ADC_W-1){1'b1}}});
  endfunction

  // fibonacci taps of x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_word(output logic [`ADC_W-1:0] w);
    w = '0;
    for (int b = 0; b < `ADC_W; b++) begin
      lfsr_q = lfsr_step(lfsr_q);  // one step per bit
      w      = {w[`ADC_W-2:0], lfsr_q[0]};
    end
  endtask

  task automatic check_val(input string name, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    if (act_v !== exp_v) begin
      errors++;
      $display("error at %0t: %s expected %h got %h", $time, name, exp_v, act_v);
      $display(">>> FAIL");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic set_row(input int r, input logic [`ACQ_UNITS-1:0] a, input sample_t lvl,
                         input logic [`ACQ_UNITS-1:0] d,
                         input logic [`ADC_CH-1:0][`ADC_W-1:0] st,
                         input logic [`ADC_CH-1:0][`ADC_W-1:0] sp);
    arm_tab[r]   = a;
    lvl_tab[r]   = lvl;
    done_tab[r]  = d;
    start_tab[r] = st;
    step_tab[r]  = sp;
  endtask

  // channel 3 leads each concatenation
  // a negative raw step makes a rising sample
  task automatic fill_table();
    // ch0 from -50 by +10, level 100, unit 0 only
    set_row(0, 2'b01, 14'sd100, 2'b01,
            {14'h0000, 14'h1000, 14'h0000, 14'h2031},
            {14'h0000, 14'h0007, 14'h0000, 14'h3ff6});
    // ch2 starts above level, wraps low, crosses again
    set_row(1, 2'b10, 14'sd0, 2'b11,
            {14'h0123, 14'h0c77, 14'h0000, 14'h0000},
            {14'h0005, 14'h3c18, 14'h0000, 14'h0000});
    // both units in the same row
    set_row(2, 2'b11, 14'sd0, 2'b11,
            {14'h0000, 14'h212b, 14'h0000, 14'h2031},
            {14'h0000, 14'h3fe7, 14'h0000, 14'h3ff6});
    // re-arm unit 0 while unit 1 region must survive
    set_row(3, 2'b01, 14'sd0, 2'b11,
            {14'h0000, 14'h0000, 14'h0000, 14'h2f9f},
            {14'h0000, 14'h0000, 14'h0000, 14'h3ed4});
  endtask

  task automatic build_wave(input int r);
    logic [`ADC_W-1:0] v;
    for (int i = 0; i < N_SMP; i++) begin
      for (int ch = 0; ch < `ADC_CH; ch++) begin
        if (step_tab[r][ch] != '0) v = start_tab[r][ch] + step_tab[r][ch] * AW'(i);
        else rand_word(v);
        wave[i][ch] = v;
      end
    end
  endtask

  ////////////////////
  // reference model
  ////////////////////

  // first rising crossing from the arm cycle on, then every ACQ_DECIM-th pair
  task automatic model_unit(input int u);
    int        trig;
    sample_t   a_now;
    sample_t   a_prev;
    mem_word_t w;
    trig = -1;
    for (int j = ARM_AT; j < N_SMP; j++) begin
      a_now  = convert_raw(wave[j][2*u]);
      a_prev = convert_raw(wave[j-1][2*u]);  // sample before arm only seeds
      if (trig < 0 && a_now >= trig_level && a_prev < trig_level) trig = j;
    end
    if (trig < 0 || trig + `ACQ_DECIM * (`ACQ_DEPTH - 1) >= N_SMP) begin
      $display("row stimulus has no usable rising crossing for unit %0d", u);
      $display(">>> FAIL");
      $fatal(1, "bad stimulus row");
    end
    for (int k = 0; k < `ACQ_DEPTH; k++) begin
      w.a = convert_raw(wave[trig + `ACQ_DECIM * k][2*u]);
      w.b = convert_raw(wave[trig + `ACQ_DECIM * k][2*u + 1]);
      exp_mem[u * `ACQ_DEPTH + k] = w;
    end
    exp_valid[u] = 1'b1;
  endtask

  ////////////////////
  // row phases
  ////////////////////

  task automatic run_row(input int r);
    for (int i = 0; i < N_SMP; i++) begin
      @(posedge adc_clk_01);
      #(DRV_DLY);
      if (i == ARM_AT + 1) begin
        for (int u = 0; u < `ACQ_UNITS; u++) begin
          if (arm_tab[r][u]) check_val($sformatf("done_o[%0d]", u), 32'd0, 32'(done[u]));
        end
      end
      for (int ch = 0; ch < `ADC_CH; ch++) adc_dat[ch] = wave[i][ch];
      arm = (i == ARM_AT) ? arm_tab[r] : '0;  // one-cycle arm pulse
    end
  endtask

  task automatic wait_done(input logic [`ACQ_UNITS-1:0] mask);
    int n;
    n = 0;
    while (((done & mask) != mask) && (n < DONE_TMO)) begin
      @(posedge adc_clk_01);
      #(DRV_DLY);
      n++;
    end
    if ((done & mask) != mask) begin
      $display("timeout: done_o stayed low for units %b", mask);
      $display(">>> FAIL");
      $fatal(1, "done_o timeout");
    end
  endtask

  // address a goes out while data of a-1 comes back
  task automatic read_back();
    for (int a = 0; a <= N_WORDS; a++) begin
      @(posedge adc_clk_01);
      #(DRV_DLY);
      if (a > 0 && exp_valid[unit_id_t'((a - 1) / `ACQ_DEPTH)]) begin
        check_val($sformatf("rd_data_o[%0d]", a - 1), 32'(exp_mem[a-1]), 32'(rd_data));
      end
      if (a < N_WORDS) rd_addr = mem_addr_t'(a);
    end
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    adc_dat    = '0;
    arm        = '0;
    trig_level = '0;
    rd_addr    = '0;
    lfsr_q     = 16'd38058;
    errors     = 0;
    exp_valid  = '0;
    fill_table();
    wait (reset_i == 1'b0);
    @(posedge adc_clk_01);
    #(DRV_DLY);
    check_val("done_o", 32'd0, 32'(done));  // nothing captured yet
    for (int r = 0; r < N_ROWS; r++) begin
      trig_level = lvl_tab[r];
      build_wave(r);
      run_row(r);
      wait_done(arm_tab[r]);
      check_val("done_o", 32'(done_tab[r]), 32'(done));
      for (int u = 0; u < `ACQ_UNITS; u++) begin
        if (arm_tab[r][u]) model_unit(u);
      end
      read_back();  // whole memory including untouched regions
    end
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // watchdog sized from rows, waveform length and readback
  initial begin
    #(WDOG_T);
    $display("watchdog: run did not finish within %0d time units", WDOG_T);
    $display(">>> FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: filelist.f
+incdir+hw
hw/sample_pkg.sv
hw/mem_wr_pkg.sv
hw/mem_wr_if.sv
hw/adc_frontend.sv
hw/capture_unit.sv
hw/sample_arbiter.sv
hw/sample_ram.sv
hw/acq_top.sv
sim/acq_clkgen.sv
sim/acq_sva.sv
sim/acq_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the capture core testbench with Verilator, runs it and scans the log for the result
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module acq_tb -f filelist.f -o acq_sim \
  || { echo "build failed"; exit 1; }
./obj_dir/acq_sim > sim.log 2>&1 \
  || echo "simulator returned an error status" >> sim.log
cat sim.log
grep -q ">>> FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "simulator returned an error status" sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"
exit 0
